// ==== logic/sifh_pkg.sv ====
package sifh_pkg;

    // arrival bin address width, 16 bins per pixel
    localparam int BIN_W = 4;

    // pixel index width, room for up to 8 pixels
    localparam int PIX_W = 3;

    // histogram count width
    localparam int CNT_W = 8;

    // quantized arrival bin
    typedef logic [BIN_W-1:0] bin_t;

    // pixel under service
    typedef logic [PIX_W-1:0] pix_t;

    // occupancy of one bin
    typedef logic [CNT_W-1:0] cnt_t;

    // hit as it leaves the sequencer
    // frame_last marks the hit that closes the frame
    typedef struct packed {
        pix_t pixel;
        bin_t bin;
        logic frame_last;
    } tagged_hit_t;

    // bin update as it leaves the histogram bank
    // count is the bin value after the increment
    typedef struct packed {
        pix_t pixel;
        bin_t bin;
        cnt_t count;
        logic frame_last;
    } bin_update_t;

endpackage

// ==== logic/hit_sequencer.sv ====
`timescale 1ns/1ps

module hit_sequencer
    import sifh_pkg::*;
#(
    parameter int PIXEL_NUM      = 4,
    parameter int HITS_PER_PIXEL = 3,
    parameter int ACQ_NUM        = 5
) (
    input  logic        clk,
    input  logic        combin_res,
    input  logic        wr_en,
    input  bin_t        addr,
    output logic        hit_valid,
    output tagged_hit_t hit,
    output logic        acq_last
);

    // counter widths, at least one bit each
    localparam int HIT_W = (HITS_PER_PIXEL > 1) ? $clog2(HITS_PER_PIXEL) : 1;
    localparam int ACQ_W = (ACQ_NUM > 1) ? $clog2(ACQ_NUM) : 1;

    logic [HIT_W-1:0] hit_cnt;
    pix_t             pix_cnt;
    logic [ACQ_W-1:0] acq_cnt;

    logic hit_end;
    logic pix_end;
    logic acq_end;
    logic frame_end;

    // wrap conditions of the three nested counters
    assign hit_end   = (hit_cnt == HIT_W'(HITS_PER_PIXEL - 1));
    assign pix_end   = (pix_cnt == pix_t'(PIXEL_NUM - 1));
    assign acq_end   = (acq_cnt == ACQ_W'(ACQ_NUM - 1));
    // current hit closes the last pixel of the last acquisition
    assign frame_end = hit_end & pix_end & acq_end;

    // nested counters, only move on a hit
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            hit_cnt  <= '0;
            pix_cnt  <= '0;
            acq_cnt  <= '0;
            acq_last <= 1'b0;
        end else if (wr_en) begin
            if (hit_end) begin
                hit_cnt <= '0;
                if (pix_end) begin
                    pix_cnt <= '0;
                    if (acq_end) begin
                        acq_cnt <= '0;
                    end else begin
                        acq_cnt <= acq_cnt + 1'b1;
                    end
                end else begin
                    pix_cnt <= pix_cnt + 1'b1;
                end
            end else begin
                hit_cnt <= hit_cnt + 1'b1;
            end
            // final acquisition starts once the one before it completes
            if (frame_end) begin
                acq_last <= 1'b0;
            end else if (hit_end && pix_end && acq_cnt == ACQ_W'(ACQ_NUM - 2)) begin
                acq_last <= 1'b1;
            end
        end
    end

    // strobe follows wr_en by one edge
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            hit_valid <= 1'b0;
        end else begin
            hit_valid <= wr_en;
        end
    end

    // tag with the pixel current when the hit arrives
    always_ff @(posedge clk) begin
        if (wr_en) begin
            hit.pixel      <= pix_cnt;
            hit.bin        <= addr;
            hit.frame_last <= frame_end;
        end
    end

    // pixel counter wraps before reaching the pixel count
    a_pix_range : assert property (@(posedge clk) disable iff (!combin_res)
        int'(pix_cnt) < PIXEL_NUM)
        else $error("pixel counter out of range: %0d", pix_cnt);

endmodule

// ==== logic/histogram_bank.sv ====
`timescale 1ns/1ps

module histogram_bank
    import sifh_pkg::*;
#(
    parameter int PIXEL_NUM = 4
) (
    input  logic        clk,
    input  logic        combin_res,
    input  logic        hit_valid,
    input  tagged_hit_t hit,
    output logic        upd_valid,
    output bin_update_t upd
);

    localparam int BIN_NUM = 2 ** BIN_W;

    // counts per pixel and bin, plain registers
    cnt_t               counts  [PIXEL_NUM][BIN_NUM];
    // one valid bit per bin, cleared bins read as empty
    logic [BIN_NUM-1:0] bin_vld [PIXEL_NUM];

    logic rd_vld;
    cnt_t rd_cnt;
    cnt_t new_cnt;

    // read side of the read-modify-write
    always_comb begin
        rd_vld = 1'b0;
        rd_cnt = '0;
        for (int p = 0; p < PIXEL_NUM; p++) begin
            if (pix_t'(p) == hit.pixel) begin
                rd_vld = bin_vld[p][hit.bin];
                rd_cnt = counts[p][hit.bin];
            end
        end
        // stale count is ignored on an invalid bin
        new_cnt = rd_vld ? rd_cnt + cnt_t'(1) : cnt_t'(1);
    end

    // count write, same edge as the read
    always_ff @(posedge clk) begin
        for (int p = 0; p < PIXEL_NUM; p++) begin
            if (hit_valid && pix_t'(p) == hit.pixel) begin
                counts[p][hit.bin] <= new_cnt;
            end
        end
    end

    // valid bits, frame end empties the whole bank at once
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < PIXEL_NUM; p++) begin
                bin_vld[p] <= '0;
            end
        end else if (hit_valid) begin
            for (int p = 0; p < PIXEL_NUM; p++) begin
                if (hit.frame_last) begin
                    bin_vld[p] <= '0;
                end else if (pix_t'(p) == hit.pixel) begin
                    bin_vld[p][hit.bin] <= 1'b1;
                end
            end
        end
    end

    // update towards the peak tracker
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            upd_valid <= 1'b0;
        end else begin
            upd_valid <= hit_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (hit_valid) begin
            upd.pixel      <= hit.pixel;
            upd.bin        <= hit.bin;
            upd.count      <= new_cnt;
            upd.frame_last <= hit.frame_last;
        end
    end

    // counts must not roll over within a frame
    a_no_wrap : assert property (@(posedge clk) disable iff (!combin_res)
        hit_valid && rd_vld |-> rd_cnt != '1)
        else $error("bin count wraps at pixel %0d bin %0d", hit.pixel, hit.bin);

    // sequencer never tags a pixel outside the bank
    a_pix_addr : assert property (@(posedge clk) disable iff (!combin_res)
        hit_valid |-> int'(hit.pixel) < PIXEL_NUM)
        else $error("write to missing pixel %0d", hit.pixel);

endmodule

// ==== logic/peak_tracker.sv ====
`timescale 1ns/1ps

module peak_tracker
    import sifh_pkg::*;
#(
    parameter int PIXEL_NUM = 4
) (
    input  logic        clk,
    input  logic        combin_res,
    input  logic        upd_valid,
    input  bin_update_t upd,
    output logic        peak_valid,
    output pix_t        peak_pixel,
    output bin_t        peak_bin,
    output cnt_t        peak_count,
    output logic        peak_done,
    output logic        his_num
);

    // running maxima of the frame in progress
    cnt_t run_cnt  [PIXEL_NUM];
    bin_t run_bin  [PIXEL_NUM];
    // maxima including this cycle's update
    cnt_t fold_cnt [PIXEL_NUM];
    bin_t fold_bin [PIXEL_NUM];
    // frozen copy for readout
    cnt_t snap_cnt [PIXEL_NUM];
    bin_t snap_bin [PIXEL_NUM];

    pix_t rd_idx;
    logic frame_end;

    assign frame_end = upd_valid & upd.frame_last;

    // strictly greater only, first bin to reach a count keeps it
    always_comb begin
        for (int i = 0; i < PIXEL_NUM; i++) begin
            fold_cnt[i] = run_cnt[i];
            fold_bin[i] = run_bin[i];
            if (upd_valid && pix_t'(i) == upd.pixel && upd.count > run_cnt[i]) begin
                fold_cnt[i] = upd.count;
                fold_bin[i] = upd.bin;
            end
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int i = 0; i < PIXEL_NUM; i++) begin
                run_cnt[i] <= '0;
                run_bin[i] <= '0;
            end
            peak_valid <= 1'b0;
            peak_done  <= 1'b0;
            rd_idx     <= '0;
            his_num    <= 1'b0;
        end else begin
            peak_done <= 1'b0;
            // readout walks one pixel per cycle
            if (peak_valid) begin
                if (rd_idx == pix_t'(PIXEL_NUM - 1)) begin
                    peak_valid <= 1'b0;
                    peak_done  <= 1'b1;
                    rd_idx     <= '0;
                end else begin
                    rd_idx <= rd_idx + 1'b1;
                end
            end
            if (frame_end) begin
                // next frame starts from zero
                for (int i = 0; i < PIXEL_NUM; i++) begin
                    run_cnt[i] <= '0;
                    run_bin[i] <= '0;
                end
                his_num    <= ~his_num;
                peak_valid <= 1'b1;
                rd_idx     <= '0;
            end else begin
                for (int i = 0; i < PIXEL_NUM; i++) begin
                    run_cnt[i] <= fold_cnt[i];
                    run_bin[i] <= fold_bin[i];
                end
            end
        end
    end

    // snapshot takes the final update too
    always_ff @(posedge clk) begin
        if (frame_end) begin
            for (int i = 0; i < PIXEL_NUM; i++) begin
                snap_cnt[i] <= fold_cnt[i];
                snap_bin[i] <= fold_bin[i];
            end
        end
    end

    // readout mux
    always_comb begin
        peak_pixel = rd_idx;
        peak_bin   = '0;
        peak_count = '0;
        for (int i = 0; i < PIXEL_NUM; i++) begin
            if (pix_t'(i) == rd_idx) begin
                peak_bin   = snap_bin[i];
                peak_count = snap_cnt[i];
            end
        end
    end

    // readout index stays inside the pixel range
    a_rd_range : assert property (@(posedge clk) disable iff (!combin_res)
        peak_valid |-> int'(rd_idx) < PIXEL_NUM)
        else $error("readout index %0d past last pixel", rd_idx);

    // a frame is always longer than its readout
    a_no_overlap : assert property (@(posedge clk) disable iff (!combin_res)
        frame_end |-> !peak_valid || rd_idx == pix_t'(PIXEL_NUM - 1))
        else $error("frame end during readout of previous frame");

endmodule

// ==== logic/sifh_histogrammer_top.sv ====
`timescale 1ns/1ps

module sifh_histogrammer_top
    import sifh_pkg::*;
#(
    parameter int PIXEL_NUM      = 4,
    parameter int HITS_PER_PIXEL = 3,
    parameter int ACQ_NUM        = 5
) (
    input  logic clk,
    input  logic combin_res,
    input  logic wr_en,
    input  bin_t addr,
    output logic acq_last,
    output logic peak_valid,
    output pix_t peak_pixel,
    output bin_t peak_bin,
    output cnt_t peak_count,
    output logic peak_done,
    output logic his_num
);

    // sequencer to bank
    logic        hit_valid;
    tagged_hit_t hit;

    // bank to tracker
    logic        upd_valid;
    bin_update_t upd;

    // tags hits with pixel and frame end
    hit_sequencer #(
        .PIXEL_NUM      (PIXEL_NUM),
        .HITS_PER_PIXEL (HITS_PER_PIXEL),
        .ACQ_NUM        (ACQ_NUM)
    ) i_hit_sequencer (
        .clk        (clk),
        .combin_res (combin_res),
        .wr_en      (wr_en),
        .addr       (addr),
        .hit_valid  (hit_valid),
        .hit        (hit),
        .acq_last   (acq_last)
    );

    // per-pixel histograms
    histogram_bank #(
        .PIXEL_NUM (PIXEL_NUM)
    ) i_histogram_bank (
        .clk        (clk),
        .combin_res (combin_res),
        .hit_valid  (hit_valid),
        .hit        (hit),
        .upd_valid  (upd_valid),
        .upd        (upd)
    );

    // peak search and readout
    peak_tracker #(
        .PIXEL_NUM (PIXEL_NUM)
    ) i_peak_tracker (
        .clk        (clk),
        .combin_res (combin_res),
        .upd_valid  (upd_valid),
        .upd        (upd),
        .peak_valid (peak_valid),
        .peak_pixel (peak_pixel),
        .peak_bin   (peak_bin),
        .peak_count (peak_count),
        .peak_done  (peak_done),
        .his_num    (his_num)
    );

endmodule

// ==== dv/sifh_tb_model.sv ====
`timescale 1ns/1ps

module sifh_tb_model
    import sifh_pkg::*;
#(
    parameter int PIXEL_NUM      = 4,
    parameter int HITS_PER_PIXEL = 3,
    parameter int ACQ_NUM        = 5
) (
    input  logic clk,
    input  logic combin_res,
    input  logic wr_en,
    input  bin_t addr,
    input  logic acq_last,
    input  logic peak_valid,
    input  pix_t peak_pixel,
    input  bin_t peak_bin,
    input  cnt_t peak_count,
    input  logic peak_done,
    input  logic his_num,
    output int   value_errors,
    output int   done_count
);

    localparam int BIN_NUM = 2 ** BIN_W;

    // model histogram and running peaks of the open frame
    int ref_cnt  [PIXEL_NUM][BIN_NUM];
    int ref_peak [PIXEL_NUM];
    int ref_bin  [PIXEL_NUM];
    // peaks frozen when a frame closes
    int snap_peak [PIXEL_NUM];
    int snap_bin  [PIXEL_NUM];

    // nested hit, pixel and acquisition counters
    int hit_c;
    int pix_c;
    int acq_c;

    // cycles left until the readout starts
    int start_dly;
    int exp_idx;
    int err_cnt = 0;
    int rd_seen = 0;

    logic exp_valid;
    logic exp_done;
    logic exp_his;
    logic exp_acq_last;

    assign value_errors = err_cnt;
    assign done_count   = rd_seen;

    task automatic clear_histogram();
        for (int p = 0; p < PIXEL_NUM; p++) begin
            for (int b = 0; b < BIN_NUM; b++) begin
                ref_cnt[p][b] = 0;
            end
            ref_peak[p] = 0;
            ref_bin[p]  = 0;
        end
    endtask

    // freeze the peaks and start from empty bins
    task automatic close_frame();
        for (int p = 0; p < PIXEL_NUM; p++) begin
            snap_peak[p] = ref_peak[p];
            snap_bin[p]  = ref_bin[p];
        end
        clear_histogram();
        // hit edge, then bank edge, then tracker edge
        start_dly = 2;
    endtask

    task automatic record_hit(input bin_t bin);
        int p;
        p = pix_c;
        ref_cnt[p][bin]++;
        // only a strictly higher count moves the peak
        if (ref_cnt[p][bin] > ref_peak[p]) begin
            ref_peak[p] = ref_cnt[p][bin];
            ref_bin[p]  = int'(bin);
        end
        hit_c++;
        if (hit_c == HITS_PER_PIXEL) begin
            hit_c = 0;
            pix_c++;
            if (pix_c == PIXEL_NUM) begin
                pix_c = 0;
                acq_c++;
                if (acq_c == ACQ_NUM) begin
                    acq_c = 0;
                    close_frame();
                end
            end
        end
        // high for the whole final acquisition
        exp_acq_last = (acq_c == ACQ_NUM - 1);
    endtask

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        assert (actual === expected) else begin
            err_cnt++;
            $display("FAIL t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
        end
    endtask

    // model advances on the same edges as the DUT
    always @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            clear_histogram();
            hit_c        = 0;
            pix_c        = 0;
            acq_c        = 0;
            start_dly    = 0;
            exp_idx      = 0;
            exp_valid    = 1'b0;
            exp_done     = 1'b0;
            exp_his      = 1'b0;
            exp_acq_last = 1'b0;
        end else begin
            exp_done = 1'b0;
            // one pixel per cycle, done right after the last
            if (exp_valid) begin
                if (exp_idx == PIXEL_NUM - 1) begin
                    exp_valid = 1'b0;
                    exp_done  = 1'b1;
                end else begin
                    exp_idx++;
                end
            end
            if (start_dly == 1) begin
                exp_valid = 1'b1;
                exp_idx   = 0;
                exp_his   = ~exp_his;
            end
            if (start_dly > 0) begin
                start_dly--;
            end
            if (wr_en) begin
                record_hit(addr);
            end
        end
    end

    // outputs are settled half a cycle after the edge
    always @(negedge clk) begin
        compare_value("acq_last", 32'(exp_acq_last), 32'(acq_last));
        compare_value("peak_valid", 32'(exp_valid), 32'(peak_valid));
        compare_value("peak_done", 32'(exp_done), 32'(peak_done));
        compare_value("his_num", 32'(exp_his), 32'(his_num));
        if (exp_valid) begin
            compare_value("peak_pixel", exp_idx, 32'(peak_pixel));
            compare_value("peak_bin", snap_bin[exp_idx], 32'(peak_bin));
            compare_value("peak_count", snap_peak[exp_idx], 32'(peak_count));
        end
        if (peak_done === 1'b1) begin
            rd_seen++;
        end
    end

endmodule

// ==== dv/sifh_tb.sv ====
`timescale 1ns/1ps

module sifh_tb
    import sifh_pkg::*;
();

    localparam int PIXEL_NUM      = 4;
    localparam int HITS_PER_PIXEL = 3;
    localparam int ACQ_NUM        = 5;
    localparam int FRAME_NUM      = 4;
    localparam int FRAME_HITS     = PIXEL_NUM * HITS_PER_PIXEL * ACQ_NUM;
    // idle gaps can double a frame, plus reset and readout slack
    localparam int TIMEOUT_CYCLES = FRAME_NUM * FRAME_HITS * 2 + 200;

    logic clk = 1'b0;
    logic combin_res;
    logic wr_en;
    bin_t addr;
    logic acq_last;
    logic peak_valid;
    pix_t peak_pixel;
    bin_t peak_bin;
    cnt_t peak_count;
    logic peak_done;
    logic his_num;

    int value_errors;
    int done_count;
    int other_errors = 0;
    int cycle_count  = 0;

    // 4 ns period
    always #2 clk = ~clk;

    sifh_histogrammer_top #(
        .PIXEL_NUM      (PIXEL_NUM),
        .HITS_PER_PIXEL (HITS_PER_PIXEL),
        .ACQ_NUM        (ACQ_NUM)
    ) i_dut (
        .clk        (clk),
        .combin_res (combin_res),
        .wr_en      (wr_en),
        .addr       (addr),
        .acq_last   (acq_last),
        .peak_valid (peak_valid),
        .peak_pixel (peak_pixel),
        .peak_bin   (peak_bin),
        .peak_count (peak_count),
        .peak_done  (peak_done),
        .his_num    (his_num)
    );

    // reference model and all value checks
    sifh_tb_model #(
        .PIXEL_NUM      (PIXEL_NUM),
        .HITS_PER_PIXEL (HITS_PER_PIXEL),
        .ACQ_NUM        (ACQ_NUM)
    ) i_model (
        .clk          (clk),
        .combin_res   (combin_res),
        .wr_en        (wr_en),
        .addr         (addr),
        .acq_last     (acq_last),
        .peak_valid   (peak_valid),
        .peak_pixel   (peak_pixel),
        .peak_bin     (peak_bin),
        .peak_count   (peak_count),
        .peak_done    (peak_done),
        .his_num      (his_num),
        .value_errors (value_errors),
        .done_count   (done_count)
    );

    // called 1 ns after a rising edge, returns at the same point
    task automatic send_hit(input bin_t bin);
        wr_en = 1'b1;
        addr  = bin;
        @(posedge clk);
        #1;
        wr_en = 1'b0;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #1;
    endtask

    // 0 random, 1 random with gaps, 2 one bin per pixel, 3 three-way tie
    task automatic run_frame(input int mode);
        bin_t bin;
        for (int a = 0; a < ACQ_NUM; a++) begin
            for (int p = 0; p < PIXEL_NUM; p++) begin
                for (int h = 0; h < HITS_PER_PIXEL; h++) begin
                    case (mode)
                        0: bin = bin_t'($urandom);
                        1: begin
                            if ($urandom_range(1) == 1) begin
                                idle_cycle();
                            end
                            bin = bin_t'($urandom);
                        end
                        2: bin = bin_t'(3 * p + 1);
                        // each bin ends at the same count, earliest must win
                        default: bin = (h == 0) ? bin_t'(13 - p) :
                                       (h == 1) ? bin_t'(2 + p) : bin_t'(7);
                    endcase
                    send_hit(bin);
                end
            end
        end
    endtask

    task automatic wait_readout();
        do begin
            @(negedge clk);
        end while (peak_done !== 1'b1);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout: no end of run after %0d cycles, %0d value mismatches so far",
                     TIMEOUT_CYCLES, value_errors);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        combin_res = 1'b0;
        wr_en      = 1'b0;
        addr       = '0;
        void'($urandom(42));
        repeat (3) @(posedge clk);
        #1;
        combin_res = 1'b1;
        idle_cycle();
        // frame 1 readout runs while frame 2 streams in
        run_frame(0);
        run_frame(1);
        wait_readout();
        idle_cycle();
        run_frame(2);
        wait_readout();
        idle_cycle();
        run_frame(3);
        wait_readout();
        repeat (4) @(negedge clk);
        if (done_count != FRAME_NUM) begin
            other_errors++;
            $display("expected %0d readouts but saw %0d", FRAME_NUM, done_count);
        end
        $display("errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== sifh_histogrammer.f ====
logic/sifh_pkg.sv
logic/hit_sequencer.sv
logic/histogram_bank.sv
logic/peak_tracker.sv
logic/sifh_histogrammer_top.sv
dv/sifh_tb_model.sv
dv/sifh_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing --assert -Wno-fatal
TOP       ?= sifh_tb
FILELIST  ?= sifh_histogrammer.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
